// ==== hw/vld_pkg.sv ====
package vld_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Lane and word geometry
  localparam int unsigned NrLanes          = 2;
  localparam int unsigned ElenBytes        = 8;
  localparam int unsigned VrfWordBytes     = NrLanes * ElenBytes;
  // One memory read beat
  localparam int unsigned BeatBytes        = 8;
  // Queue depths
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  // Register-file words that make up one vector register
  localparam int unsigned WordsPerVreg     = 8;

  // Pointer widths of the two queues
  localparam int unsigned InsnPntWidth     = $clog2(InsnQueueDepth);
  localparam int unsigned ResPntWidth      = $clog2(ResultQueueDepth);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [2:0]  vid_t;
  typedef logic [4:0]  vreg_t;
  typedef logic [7:0]  vlen_t;
  typedef logic [7:0]  vaddr_t;
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;
  typedef logic [63:0] beat_t;

  // Queue pointers wrap naturally, counts need one extra bit
  typedef logic [InsnPntWidth-1:0] insn_pnt_t;
  typedef logic [InsnPntWidth:0]   insn_cnt_t;
  typedef logic [ResPntWidth-1:0]  res_pnt_t;
  typedef logic [ResPntWidth:0]    res_cnt_t;

  // Byte pointers inside a beat and inside a full word
  typedef logic [$clog2(BeatBytes):0]    beat_pnt_t;
  typedef logic [$clog2(VrfWordBytes):0] word_pnt_t;

  // Element width, bytes per element is 2^vsew
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

endpackage

// ==== hw/vld_insn_queue.sv ====
module vld_insn_queue (
  input  logic           clk_i,
  input  logic           rst_ni,
  // New instructions
  input  logic           insn_valid_i,
  input  vld_pkg::vid_t  insn_id_i,
  input  vld_pkg::vreg_t insn_vd_i,
  input  vld_pkg::vlen_t insn_vl_i,
  input  vld_pkg::vsew_e insn_vsew_i,
  output logic           insn_ready_o,
  // Instruction at the issue pointer
  output logic           issue_valid_o,
  output vld_pkg::vlen_t issue_bytes_o,
  output vld_pkg::vid_t  issue_id_o,
  output vld_pkg::vreg_t issue_vd_o,
  // Phase completion from packer and result queue
  input  logic           issue_done_i,
  input  logic           commit_done_i,
  // Completion response
  output logic           done_o,
  output vld_pkg::vid_t  done_id_o
);
  import vld_pkg::*;

  // Instruction storage with one slot per queue entry
  vid_t  id_q   [InsnQueueDepth];
  vreg_t vd_q   [InsnQueueDepth];
  vlen_t vl_q   [InsnQueueDepth];
  vsew_e vsew_q [InsnQueueDepth];

  // Three phases with a pointer each
  insn_pnt_t accept_pnt_q;
  insn_pnt_t issue_pnt_q;
  insn_pnt_t commit_pnt_q;
  // Instructions still to issue and still to commit
  insn_cnt_t issue_cnt_q;
  insn_cnt_t commit_cnt_q;

  logic accept;

  // Room left while fewer than the full depth are in flight
  assign insn_ready_o = (commit_cnt_q != insn_cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;

  //////////////////////////////
  // Issue side
  //////////////////////////////

  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_id_o    = id_q[issue_pnt_q];
  assign issue_vd_o    = vd_q[issue_pnt_q];
  // Byte count is vl scaled by element width
  assign issue_bytes_o = vlen_t'(vl_q[issue_pnt_q] << vsew_q[issue_pnt_q]);

  // Slot write on accept and done id capture from the committing slot
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]   <= insn_id_i;
      vd_q[accept_pnt_q]   <= insn_vd_i;
      vl_q[accept_pnt_q]   <= insn_vl_i;
      vsew_q[accept_pnt_q] <= insn_vsew_i;
    end
    if (commit_done_i) begin
      done_id_o <= id_q[commit_pnt_q];
    end
  end

  // Pointer and count bookkeeping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit_done_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + insn_cnt_t'(accept) - insn_cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + insn_cnt_t'(accept) - insn_cnt_t'(commit_done_i);
      // Done pulse one cycle after the last pop
      done_o       <= commit_done_i;
    end
  end

  // Issue ends only for an instruction that is issuing
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> issue_valid_o);

  // Commit only for an instruction that has finished issuing
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_done_i |-> (commit_cnt_q > issue_cnt_q));

endmodule

// ==== hw/vld_beat_packer.sv ====
module vld_beat_packer (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Instruction being issued
  input  logic                                    issue_valid_i,
  input  vld_pkg::vlen_t                          issue_bytes_i,
  // Memory read beats
  input  logic                                    beat_valid_i,
  input  vld_pkg::beat_t                          beat_data_i,
  output logic                                    beat_ready_o,
  // Result queue
  input  logic                                    res_full_i,
  output logic                                    word_push_o,
  output vld_pkg::elen_t [vld_pkg::NrLanes-1:0]   word_data_o,
  output vld_pkg::strb_t [vld_pkg::NrLanes-1:0]   word_be_o,
  output vld_pkg::vaddr_t                         word_idx_o,
  output logic                                    word_last_o,
  output logic                                    issue_done_o
);
  import vld_pkg::*;

  // Read position in the current beat
  beat_pnt_t beat_pnt_q, beat_pnt_nxt;
  // Write position in the staged word
  word_pnt_t word_pnt_q, word_pnt_nxt;
  // Bytes of the current instruction already packed
  vlen_t     issued_q, issued_nxt;
  // Word number inside the destination register
  vaddr_t    word_idx_q;

  // Staging word with its byte enables
  elen_t [NrLanes-1:0] stage_data_q;
  strb_t [NrLanes-1:0] stage_be_q;

  vlen_t beat_left, word_left, issue_rem, take_bw, take;
  logic  fire, last;

  //////////////////////////////
  // Byte budget
  //////////////////////////////

  assign beat_left = vlen_t'(BeatBytes) - vlen_t'(beat_pnt_q);
  assign word_left = vlen_t'(VrfWordBytes) - vlen_t'(word_pnt_q);
  assign issue_rem = issue_bytes_i - issued_q;
  // Bytes moved this cycle as limited by beat, word and instruction
  assign take_bw   = (beat_left < word_left) ? beat_left : word_left;
  assign take      = (issue_rem < take_bw) ? issue_rem : take_bw;

  // Move bytes only with room downstream
  assign fire = issue_valid_i && beat_valid_i && !res_full_i;

  // Sequential copy with byte b of the word landing in lane b/8
  always_comb begin
    int unsigned wb;
    wb           = 0;
    word_data_o  = stage_data_q;
    word_be_o    = stage_be_q;
    beat_pnt_nxt = beat_pnt_q;
    word_pnt_nxt = word_pnt_q;
    issued_nxt   = issued_q;
    if (fire) begin
      for (int unsigned b = 0; b < BeatBytes; b++) begin
        wb = b - beat_pnt_q + word_pnt_q;
        if (b >= beat_pnt_q && b < beat_pnt_q + take) begin
          word_data_o[wb / ElenBytes][8*(wb % ElenBytes) +: 8] = beat_data_i[8*b +: 8];
          word_be_o[wb / ElenBytes][wb % ElenBytes]           = 1'b1;
        end
      end
      beat_pnt_nxt = beat_pnt_q + beat_pnt_t'(take);
      word_pnt_nxt = word_pnt_q + word_pnt_t'(take);
      issued_nxt   = issued_q + take;
    end
  end

  // Last byte of the instruction arrives now
  assign last         = fire && (issued_nxt == issue_bytes_i);
  // Full word or final partial word goes out this cycle
  assign word_push_o  = fire && ((word_pnt_nxt == word_pnt_t'(VrfWordBytes)) || last);
  // Leftover bytes of the final beat are dropped
  assign beat_ready_o = fire && ((beat_pnt_nxt == beat_pnt_t'(BeatBytes)) || last);
  assign issue_done_o = last;
  assign word_last_o  = last;
  assign word_idx_o   = word_idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_pnt_q   <= '0;
      word_pnt_q   <= '0;
      issued_q     <= '0;
      word_idx_q   <= '0;
      stage_data_q <= '0;
      stage_be_q   <= '0;
    end else begin
      beat_pnt_q <= beat_ready_o ? beat_pnt_t'(0) : beat_pnt_nxt;
      // Staging word restarts empty after each push
      if (word_push_o) begin
        word_pnt_q   <= '0;
        stage_data_q <= '0;
        stage_be_q   <= '0;
      end else begin
        word_pnt_q   <= word_pnt_nxt;
        stage_data_q <= word_data_o;
        stage_be_q   <= word_be_o;
      end
      if (last) begin
        issued_q   <= '0;
        word_idx_q <= '0;
      end else begin
        issued_q <= issued_nxt;
        if (word_push_o) begin
          word_idx_q <= word_idx_q + 1'b1;
        end
      end
    end
  end

  // Never push into a full result queue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_full_i |-> !word_push_o);

  // An offered beat stays valid and unchanged until consumed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (beat_valid_i && !beat_ready_o) |=> (beat_valid_i && $stable(beat_data_i)));

endmodule

// ==== hw/vld_result_queue.sv ====
module vld_result_queue (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Packed words from the packer
  input  logic                                    word_push_i,
  input  vld_pkg::elen_t  [vld_pkg::NrLanes-1:0]  word_data_i,
  input  vld_pkg::strb_t  [vld_pkg::NrLanes-1:0]  word_be_i,
  input  vld_pkg::vaddr_t                         word_idx_i,
  input  logic                                    word_last_i,
  // Issuing instruction
  input  vld_pkg::vid_t                           issue_id_i,
  input  vld_pkg::vreg_t                          issue_vd_i,
  output logic                                    res_full_o,
  // Lane write ports
  output logic            [vld_pkg::NrLanes-1:0]  result_req_o,
  output vld_pkg::vid_t   [vld_pkg::NrLanes-1:0]  result_id_o,
  output vld_pkg::vaddr_t [vld_pkg::NrLanes-1:0]  result_addr_o,
  output vld_pkg::elen_t  [vld_pkg::NrLanes-1:0]  result_wdata_o,
  output vld_pkg::strb_t  [vld_pkg::NrLanes-1:0]  result_be_o,
  input  logic            [vld_pkg::NrLanes-1:0]  result_gnt_i,
  // Last word of an instruction written to all lanes
  output logic                                    commit_done_o
);
  import vld_pkg::*;

  // Entry payload
  elen_t [NrLanes-1:0] data_q [ResultQueueDepth];
  strb_t [NrLanes-1:0] be_q   [ResultQueueDepth];
  vaddr_t              addr_q [ResultQueueDepth];
  vid_t                id_q   [ResultQueueDepth];
  logic                last_q [ResultQueueDepth];

  // Lanes of each entry still waiting for a grant
  logic [NrLanes-1:0] pend_q [ResultQueueDepth];

  res_pnt_t wr_pnt_q;
  res_pnt_t rd_pnt_q;
  res_cnt_t cnt_q;

  vaddr_t             word_addr;
  logic [NrLanes-1:0] pend_left;
  logic               pop;

  // Register-file word address within the destination register
  assign word_addr = vaddr_t'(issue_vd_i) * vaddr_t'(WordsPerVreg) + word_idx_i;

  assign res_full_o = (cnt_q == res_cnt_t'(ResultQueueDepth));

  //////////////////////////////
  // Lane requests
  //////////////////////////////

  // Head entry drives every lane straight from registers
  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    assign result_req_o[l]   = pend_q[rd_pnt_q][l];
    assign result_id_o[l]    = id_q[rd_pnt_q];
    assign result_addr_o[l]  = addr_q[rd_pnt_q];
    assign result_wdata_o[l] = data_q[rd_pnt_q][l];
    assign result_be_o[l]    = be_q[rd_pnt_q][l];

    // Ungranted request holds with the same payload
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (result_req_o[l] && !result_gnt_i[l]) |=>
        (result_req_o[l] && $stable(result_wdata_o[l]) && $stable(result_be_o[l]) &&
         $stable(result_addr_o[l]) && $stable(result_id_o[l])));
  end

  // Pop once the final pending lane is granted
  assign pend_left     = pend_q[rd_pnt_q] & ~result_gnt_i;
  assign pop           = (cnt_q != '0) && (pend_left == '0);
  assign commit_done_o = pop && last_q[rd_pnt_q];

  // Payload capture on push
  always_ff @(posedge clk_i) begin
    if (word_push_i) begin
      data_q[wr_pnt_q] <= word_data_i;
      be_q[wr_pnt_q]   <= word_be_i;
      addr_q[wr_pnt_q] <= word_addr;
      id_q[wr_pnt_q]   <= issue_id_i;
      last_q[wr_pnt_q] <= word_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '{default: '0};
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Drop granted lanes of the head
      pend_q[rd_pnt_q] <= pend_left;
      // New entry requests every lane
      if (word_push_i) begin
        pend_q[wr_pnt_q] <= '1;
        wr_pnt_q         <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + res_cnt_t'(word_push_i) - res_cnt_t'(pop);
    end
  end

endmodule

// ==== hw/vld_top.sv ====
module vld_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Instruction in
  input  logic                                    insn_valid_i,
  input  vld_pkg::vid_t                           insn_id_i,
  input  vld_pkg::vreg_t                          insn_vd_i,
  input  vld_pkg::vlen_t                          insn_vl_i,
  input  vld_pkg::vsew_e                          insn_vsew_i,
  output logic                                    insn_ready_o,
  // Memory beats
  input  logic                                    beat_valid_i,
  input  vld_pkg::beat_t                          beat_data_i,
  output logic                                    beat_ready_o,
  // Lane writes
  output logic            [vld_pkg::NrLanes-1:0]  result_req_o,
  output vld_pkg::vid_t   [vld_pkg::NrLanes-1:0]  result_id_o,
  output vld_pkg::vaddr_t [vld_pkg::NrLanes-1:0]  result_addr_o,
  output vld_pkg::elen_t  [vld_pkg::NrLanes-1:0]  result_wdata_o,
  output vld_pkg::strb_t  [vld_pkg::NrLanes-1:0]  result_be_o,
  input  logic            [vld_pkg::NrLanes-1:0]  result_gnt_i,
  // Completion
  output logic                                    done_o,
  output vld_pkg::vid_t                           done_id_o
);
  import vld_pkg::*;

  // Issue side of the instruction queue
  logic  issue_valid;
  vlen_t issue_bytes;
  vid_t  issue_id;
  vreg_t issue_vd;
  logic  issue_done;

  // Packer to result queue
  logic                word_push;
  elen_t [NrLanes-1:0] word_data;
  strb_t [NrLanes-1:0] word_be;
  vaddr_t              word_idx;
  logic                word_last;

  // Result queue status
  logic res_full;
  logic commit_done;

  vld_insn_queue u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_valid_i  (insn_valid_i),
    .insn_id_i     (insn_id_i),
    .insn_vd_i     (insn_vd_i),
    .insn_vl_i     (insn_vl_i),
    .insn_vsew_i   (insn_vsew_i),
    .insn_ready_o  (insn_ready_o),
    .issue_valid_o (issue_valid),
    .issue_bytes_o (issue_bytes),
    .issue_id_o    (issue_id),
    .issue_vd_o    (issue_vd),
    .issue_done_i  (issue_done),
    .commit_done_i (commit_done),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  vld_beat_packer u_beat_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid),
    .issue_bytes_i (issue_bytes),
    .beat_valid_i  (beat_valid_i),
    .beat_data_i   (beat_data_i),
    .beat_ready_o  (beat_ready_o),
    .res_full_i    (res_full),
    .word_push_o   (word_push),
    .word_data_o   (word_data),
    .word_be_o     (word_be),
    .word_idx_o    (word_idx),
    .word_last_o   (word_last),
    .issue_done_o  (issue_done)
  );

  vld_result_queue u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .word_push_i    (word_push),
    .word_data_i    (word_data),
    .word_be_i      (word_be),
    .word_idx_i     (word_idx),
    .word_last_i    (word_last),
    .issue_id_i     (issue_id),
    .issue_vd_i     (issue_vd),
    .res_full_o     (res_full),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .commit_done_o  (commit_done)
  );

endmodule

// ==== sim/tb_vld_top.sv ====
module tb_vld_top;
  timeunit 1ns;
  timeprecision 1ps;

  import vld_pkg::*;

  // Cycles any single wait may take
  localparam int unsigned Timeout   = 2000;
  // Observation window for the stalled beat stream
  localparam int unsigned StallSpan = 20;

  // One expected lane write
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  data;
    strb_t  be;
  } wr_t;

  logic clk_i;
  logic rst_ni;

  logic  insn_valid_i;
  vid_t  insn_id_i;
  vreg_t insn_vd_i;
  vlen_t insn_vl_i;
  vsew_e insn_vsew_i;
  logic  insn_ready_o;

  logic  beat_valid_i;
  beat_t beat_data_i;
  logic  beat_ready_o;

  logic   [NrLanes-1:0] result_req_o;
  vid_t   [NrLanes-1:0] result_id_o;
  vaddr_t [NrLanes-1:0] result_addr_o;
  elen_t  [NrLanes-1:0] result_wdata_o;
  strb_t  [NrLanes-1:0] result_be_o;
  logic   [NrLanes-1:0] result_gnt_i;

  logic done_o;
  vid_t done_id_o;

  // Scoreboard state
  beat_t       beat_q [$];
  wr_t         exp_wr [NrLanes][$];
  vid_t        exp_done [$];
  int unsigned done_cnt;
  int unsigned beats_taken;
  int unsigned errors;
  int unsigned checks;

  // Model controls
  logic               beat_hold;
  logic [NrLanes-1:0] gnt_off;
  logic [NrLanes-1:0] gnt_rand;
  logic [15:0]        lfsr_q;

  // Per-lane record of an ungranted request
  logic [NrLanes-1:0] held;
  wr_t                held_wr [NrLanes];

  vld_top u_vld_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r[i]   = lfsr_q[0];
      lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
    end
    return r;
  endfunction

  function automatic void check_val(input string name, input logic [63:0] got,
                                    input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endfunction

  function automatic void check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Failure at %0t: %s", $time, msg);
    end
  endfunction

  // Everything queued for a test has been used up
  function automatic void check_drained(input string what);
    check_true(beat_q.size() == 0, {"beats left unconsumed after ", what});
    check_true(exp_done.size() == 0, {"done pulse missing after ", what});
    for (int l = 0; l < NrLanes; l++) begin
      check_true(exp_wr[l].size() == 0, $sformatf("lane %0d writes missing after %s", l, what));
    end
  endfunction

  // Valid/ready handshake on the instruction port
  task automatic send_insn(input vid_t id, input vreg_t vd, input vlen_t vl, input vsew_e vsew);
    int unsigned cycles;
    logic        accepted;
    cycles   = 0;
    accepted = 1'b0;
    @(posedge clk_i);
    insn_valid_i <= 1'b1;
    insn_id_i    <= id;
    insn_vd_i    <= vd;
    insn_vl_i    <= vl;
    insn_vsew_i  <= vsew;
    while (!accepted && cycles < Timeout) begin
      @(posedge clk_i);
      accepted = insn_ready_o;
      cycles++;
    end
    insn_valid_i <= 1'b0;
    if (!accepted) begin
      check_true(1'b0, $sformatf("timeout waiting for insn_ready_o, id %0d", id));
    end
  endtask

  // Queue random beats, predict the lane words, then send the instruction
  task automatic load_insn(input vid_t id, input vreg_t vd, input vlen_t vl, input vsew_e vsew);
    int unsigned nbytes;
    int unsigned nbeats;
    int unsigned nwords;
    int unsigned b;
    logic [7:0]  bytes [128];
    beat_t       beat;
    wr_t         wr;
    nbytes = int'(vl) << int'(vsew);
    nbeats = (nbytes + BeatBytes - 1) / BeatBytes;
    nwords = (nbytes + VrfWordBytes - 1) / VrfWordBytes;
    @(negedge clk_i);
    for (int unsigned k = 0; k < nbeats; k++) begin
      beat = rand_bits(64);
      beat_q.push_back(beat);
      for (int unsigned j = 0; j < BeatBytes; j++) begin
        // Bytes past the end of the instruction are dropped
        if (k * BeatBytes + j < nbytes) begin
          bytes[k*BeatBytes+j] = beat[8*j +: 8];
        end
      end
    end
    // Byte b of a word goes to lane b/8 at offset b mod 8
    for (int unsigned w = 0; w < nwords; w++) begin
      for (int l = 0; l < NrLanes; l++) begin
        wr.id   = id;
        wr.addr = vaddr_t'(vd * WordsPerVreg + w);
        wr.data = '0;
        wr.be   = '0;
        for (int unsigned o = 0; o < ElenBytes; o++) begin
          b = w * VrfWordBytes + l * ElenBytes + o;
          if (b < nbytes) begin
            wr.data[8*o +: 8] = bytes[b];
            wr.be[o]          = 1'b1;
          end
        end
        exp_wr[l].push_back(wr);
      end
    end
    exp_done.push_back(id);
    send_insn(id, vd, vl, vsew);
  endtask

  task automatic wait_done(input int unsigned target, input string what);
    int unsigned cycles;
    cycles = 0;
    while (done_cnt < target && cycles < Timeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_cnt < target) begin
      check_true(1'b0, {"timeout waiting for done_o in ", what});
    end
  endtask

  task automatic wait_beats(input int unsigned target, input string what);
    int unsigned cycles;
    cycles = 0;
    while (beats_taken < target && cycles < Timeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (beats_taken < target) begin
      check_true(1'b0, {"timeout waiting for beats in ", what});
    end
  endtask

  //////////////////////////////
  // Models
  //////////////////////////////

  // Memory source holding each beat until consumed
  always @(posedge clk_i) begin
    if (beat_valid_i && beat_ready_o) begin
      void'(beat_q.pop_front());
      beats_taken++;
    end
    if (!(beat_valid_i && !beat_ready_o)) begin
      beat_valid_i <= !beat_hold && (beat_q.size() != 0);
      if (beat_q.size() != 0) begin
        beat_data_i <= beat_q[0];
      end
    end
  end

  // Lane write ports with each lane granted on its own
  always @(posedge clk_i) begin
    wr_t cur;
    wr_t exp;
    for (int l = 0; l < NrLanes; l++) begin
      cur = {result_id_o[l], result_addr_o[l], result_wdata_o[l], result_be_o[l]};
      if (!rst_ni) begin
        held[l]         = 1'b0;
        result_gnt_i[l] <= 1'b0;
      end else begin
        // Pending request must hold its payload
        if (held[l]) begin
          check_true(result_req_o[l] && (cur == held_wr[l]),
                     $sformatf("lane %0d request changed before its grant", l));
        end
        if (result_req_o[l] && result_gnt_i[l]) begin
          if (exp_wr[l].size() == 0) begin
            check_true(1'b0, $sformatf("unexpected write on lane %0d", l));
          end else begin
            exp = exp_wr[l].pop_front();
            check_val($sformatf("result_id_o[%0d]", l), 64'(cur.id), 64'(exp.id));
            check_val($sformatf("result_addr_o[%0d]", l), 64'(cur.addr), 64'(exp.addr));
            check_val($sformatf("result_wdata_o[%0d]", l), cur.data, exp.data);
            check_val($sformatf("result_be_o[%0d]", l), 64'(cur.be), 64'(exp.be));
          end
        end
        held[l]    = result_req_o[l] && !result_gnt_i[l];
        held_wr[l] = cur;
        // Random mode grants about one cycle in four
        if (gnt_off[l]) begin
          result_gnt_i[l] <= 1'b0;
        end else if (gnt_rand[l]) begin
          result_gnt_i[l] <= (rand_bits(2) == 64'd3);
        end else begin
          result_gnt_i[l] <= 1'b1;
        end
      end
    end
  end

  // Done pulses against acceptance order
  always @(posedge clk_i) begin
    if (rst_ni && done_o) begin
      if (exp_done.size() == 0) begin
        check_true(1'b0, "done_o pulsed with no instruction outstanding");
      end else begin
        check_val("done_id_o", 64'(done_id_o), 64'(exp_done.pop_front()));
      end
      done_cnt++;
    end
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic check_reset_state();
    @(negedge clk_i);
    check_val("insn_ready_o", 64'(insn_ready_o), 64'd1);
    check_val("beat_ready_o", 64'(beat_ready_o), 64'd0);
    check_val("result_req_o", 64'(result_req_o), 64'd0);
    check_val("done_o", 64'(done_o), 64'd0);
  endtask

  task automatic single_ew64_load();
    int unsigned base;
    base = beats_taken;
    // 4 elements of 8 bytes fill two words
    load_insn(3'd1, 5'd3, 8'd4, EW64);
    wait_done(1, "single EW64 load");
    check_val("beats consumed", 64'(beats_taken - base), 64'd4);
    check_drained("single EW64 load");
  endtask

  task automatic short_ew8_load();
    int unsigned base;
    base = beats_taken;
    // Five bytes with the rest of the beat discarded
    load_insn(3'd2, 5'd9, 8'd5, EW8);
    wait_done(2, "short EW8 load");
    check_val("beats consumed", 64'(beats_taken - base), 64'd1);
    check_drained("short EW8 load");
  endtask

  task automatic back_to_back_insns();
    beat_hold = 1'b1;
    load_insn(3'd4, 5'd1, 8'd3, EW32);
    load_insn(3'd5, 5'd2, 8'd9, EW16);
    load_insn(3'd6, 5'd3, 8'd2, EW64);
    load_insn(3'd7, 5'd4, 8'd20, EW8);
    // No beats yet so all four still occupy the queue
    @(negedge clk_i);
    check_val("insn_ready_o", 64'(insn_ready_o), 64'd0);
    beat_hold = 1'b0;
    wait_done(6, "back-to-back instructions");
    check_drained("back-to-back instructions");
  endtask

  task automatic grant_backpressure();
    int unsigned base;
    base       = beats_taken;
    gnt_off[1] = 1'b1;
    // 128 bytes fill eight words
    load_insn(3'd3, 5'd6, 8'd16, EW64);
    // Two words of two beats each fill the result queue
    wait_beats(base + 2 * ResultQueueDepth, "grant back-pressure");
    for (int unsigned i = 0; i < StallSpan; i++) begin
      @(negedge clk_i);
      check_true(!beat_ready_o, "beat consumed while the result queue is full");
    end
    check_val("beats consumed", 64'(beats_taken - base), 64'(2 * ResultQueueDepth));
    gnt_off[1]  = 1'b0;
    gnt_rand[1] = 1'b1;
    wait_done(7, "grant back-pressure");
    gnt_rand[1] = 1'b0;
    check_drained("grant back-pressure");
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    errors       = 0;
    checks       = 0;
    done_cnt     = 0;
    beats_taken  = 0;
    lfsr_q       = 16'd2;
    beat_hold    = 1'b0;
    gnt_off      = '0;
    gnt_rand     = '0;
    held         = '0;
    rst_ni       = 1'b0;
    insn_valid_i = 1'b0;
    insn_id_i    = '0;
    insn_vd_i    = '0;
    insn_vl_i    = '0;
    insn_vsew_i  = EW8;
    beat_valid_i = 1'b0;
    beat_data_i  = '0;
    result_gnt_i = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    check_reset_state();
    single_ew64_load();
    short_ew8_load();
    back_to_back_insns();
    grant_backpressure();

    repeat (5) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/vld_pkg.sv
hw/vld_insn_queue.sv
hw/vld_beat_packer.sv
hw/vld_result_queue.sv
hw/vld_top.sv
sim/tb_vld_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vld_top -f filelist.f --Mdir obj_dir -o Vtb_vld_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vld_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
